/* design/joybus_cfg.svh */
`ifndef JOYBUS_CFG_SVH
`define JOYBUS_CFG_SVH

// EEPROM geometry
`define JB_EEPROM_BYTES 2048
`define JB_ADDR_BITS 11

// Received bit is 0 when this many low sub-bits or more were seen
`define RX_ZERO_THRESHOLD 3

// Low sub-bits out of eight for each transmitted bit value
`define TX_ONE_LOW 2
`define TX_ZERO_LOW 6

`endif

/* design/joybus_pkg.sv */
package joybus_pkg;

    typedef enum logic [7:0] {
        EEPROM_STATUS = 8'h00,
        EEPROM_READ   = 8'h04,
        EEPROM_WRITE  = 8'h05,
        RTC_STATUS    = 8'h06,
        RTC_READ      = 8'h07,
        RTC_WRITE     = 8'h08
    } joybus_cmd_e;

    // Receive events from the line
    typedef struct packed {
        logic       byte_valid;
        logic [7:0] data;
        logic       stop;
        logic       timeout;
    } si_rx_t;

    // Argument byte of an accepted command
    typedef struct packed {
        logic       valid;
        logic [3:0] index;
        logic [7:0] data;
    } rx_write_t;

    // Transmit request, held until tx_busy is low
    typedef struct packed {
        logic       byte_valid;
        logic [7:0] data;
        logic       stop;
    } tx_req_t;

    typedef struct packed {
        logic       backup_wp;
        logic       time_wp;
        logic       stopped;
        logic [6:0] second;
        logic [6:0] minute;
        logic [5:0] hour;
        logic [5:0] day;
        logic [2:0] weekday;
        logic [4:0] month;
        logic [7:0] year;
    } rtc_regs_t;

endpackage

/* design/si_line_phy.sv */
`timescale 1ns/1ps
`include "joybus_cfg.svh"

module si_line_phy (
    input  logic                clk,
    input  logic                reset,
    input  logic                si_clk,
    input  logic                dq_in,
    output logic                dq_oe,
    output joybus_pkg::si_rx_t  rx,
    input  joybus_pkg::tx_req_t tx,
    output logic                tx_busy
);

    logic [1:0] si_clk_sync;
    logic [1:0] dq_sync;
    logic       si_clk_last;
    logic       dq_last;
    logic       clk_rise;
    logic       clk_fall;
    logic       dq_rise;
    logic       dq_fall;

    always_ff @(posedge clk) begin
        si_clk_sync <= {si_clk_sync[0], si_clk};
        dq_sync <= {dq_sync[0], dq_in};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            si_clk_last <= 1'b1;
            dq_last <= 1'b1;
        end else begin
            si_clk_last <= si_clk_sync[1];
            // Line is sampled only on si_clk rises
            if (clk_rise) begin
                dq_last <= dq_sync[1];
            end
        end
    end

    assign clk_rise = !si_clk_last && si_clk_sync[1];
    assign clk_fall = si_clk_last && !si_clk_sync[1];
    assign dq_fall = clk_rise && dq_last && !dq_sync[1];
    assign dq_rise = clk_rise && !dq_last && dq_sync[1];

    logic [3:0] sub_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic       rx_bit;
    logic       byte_valid;
    logic       timeout;
    logic       stop;

    // Low time since the last falling edge, saturating
    always_ff @(posedge clk) begin
        if (reset || dq_fall) begin
            sub_cnt <= '0;
        end else if (clk_rise && !(&sub_cnt)) begin
            sub_cnt <= sub_cnt + 4'd1;
        end
    end

    assign rx_bit = (sub_cnt >= 4'(`RX_ZERO_THRESHOLD)) ? 1'b0 : 1'b1;
    assign timeout = clk_rise && dq_sync[1] && (&sub_cnt);
    assign stop = clk_rise && dq_sync[1] && (sub_cnt == 4'd7) && (bit_cnt == 3'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= dq_rise && (&bit_cnt);
            if (dq_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end else if (timeout) begin
                bit_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dq_rise) begin
            rx_shift <= {rx_shift[6:0], rx_bit};
        end
    end

    always_comb begin
        rx.byte_valid = byte_valid;
        rx.data = rx_shift;
        rx.stop = stop;
        rx.timeout = timeout;
    end

    logic [2:0] tx_sub;
    logic [2:0] tx_bit;
    logic [7:0] tx_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy <= 1'b0;
            dq_oe <= 1'b0;
        end else if (tx_busy) begin
            if (clk_fall) begin
                tx_sub <= tx_sub + 3'd1;
                if (tx_shift[7]) begin
                    dq_oe <= tx_sub < 3'(`TX_ONE_LOW);
                end else begin
                    dq_oe <= tx_sub < 3'(`TX_ZERO_LOW);
                end
                if (&tx_sub) begin
                    tx_bit <= tx_bit + 3'd1;
                    tx_shift <= {tx_shift[6:0], 1'b1};
                    if (&tx_bit) begin
                        tx_busy <= 1'b0;
                    end
                end
            end
        end else if (tx.byte_valid) begin
            tx_busy <= 1'b1;
            tx_sub <= '0;
            tx_bit <= '0;
            tx_shift <= tx.data;
        end else if (tx.stop) begin
            // Stop is a single 1 bit
            tx_busy <= 1'b1;
            tx_sub <= '0;
            tx_bit <= 3'd7;
            tx_shift <= 8'hff;
        end
    end

endmodule

/* design/joybus_decode.sv */
`timescale 1ns/1ps

module joybus_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    eeprom_enabled,
    input  joybus_pkg::si_rx_t      rx,
    output joybus_pkg::joybus_cmd_e cmd,
    output logic [7:0]              block_address,
    output joybus_pkg::rx_write_t   wr,
    output logic                    reply_start
);

    import joybus_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_IGNORE
    } rx_state_e;

    rx_state_e  state;
    logic [3:0] byte_index;
    logic       accept;
    logic       arg_valid;

    always_comb begin
        case (rx.data)
            EEPROM_STATUS, EEPROM_READ, EEPROM_WRITE: accept = eeprom_enabled;
            RTC_STATUS, RTC_READ, RTC_WRITE: accept = 1'b1;
            default: accept = 1'b0;
        endcase
    end

    assign arg_valid = rx.byte_valid && (state == RX_DATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RX_IDLE;
            reply_start <= 1'b0;
        end else begin
            reply_start <= 1'b0;
            if (rx.timeout) begin
                state <= RX_IDLE;
            end else begin
                case (state)
                    RX_IDLE: begin
                        if (rx.byte_valid) begin
                            state <= accept ? RX_DATA : RX_IGNORE;
                        end
                    end
                    RX_DATA: begin
                        if (rx.stop) begin
                            reply_start <= 1'b1;
                            state <= RX_IGNORE;
                        end
                    end
                    // Wait for the end of the transfer
                    RX_IGNORE: begin
                        if (rx.stop) begin
                            state <= RX_IDLE;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.byte_valid) begin
            if (state == RX_IDLE) begin
                cmd <= joybus_cmd_e'(rx.data);
                byte_index <= '0;
            end else begin
                byte_index <= byte_index + 4'd1;
            end
        end
        if (arg_valid && (byte_index == 4'd0)) begin
            block_address <= rx.data;
        end
    end

    always_comb begin
        wr.valid = arg_valid;
        wr.index = byte_index;
        wr.data = rx.data;
    end

endmodule

/* design/joybus_exec.sv */
`timescale 1ns/1ps
`include "joybus_cfg.svh"

module joybus_exec (
    input  logic                    clk,
    input  logic                    reset,
    input  joybus_pkg::joybus_cmd_e cmd,
    input  logic [7:0]              block_address,
    input  joybus_pkg::rx_write_t   wr,
    input  logic                    byte_taken,
    output logic [7:0]              eeprom_rdata,
    output joybus_pkg::rtc_regs_t   rtc
);

    import joybus_pkg::*;

    logic [7:0]               eeprom_mem [0:`JB_EEPROM_BYTES-1];
    logic [2:0]               subaddress;
    logic [`JB_ADDR_BITS-1:0] full_address;
    logic                     eeprom_write;
    logic                     rtc_write;

    assign full_address = {block_address, subaddress};
    assign eeprom_write = wr.valid && (cmd == EEPROM_WRITE) && (wr.index != 4'd0);
    assign rtc_write = wr.valid && (cmd == RTC_WRITE);

    // Block address byte restarts the subaddress
    always_ff @(posedge clk) begin
        if (reset) begin
            subaddress <= '0;
        end else if (wr.valid && (wr.index == 4'd0)) begin
            subaddress <= '0;
        end else if (wr.valid || byte_taken) begin
            subaddress <= subaddress + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        eeprom_rdata <= eeprom_mem[full_address];
        if (eeprom_write) begin
            eeprom_mem[full_address] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rtc <= '{backup_wp: 1'b1, time_wp: 1'b1, default: '0};
        end else if (rtc_write) begin
            // Block 0 holds protection and the stopped flag
            if (block_address[1:0] == 2'd0) begin
                case (wr.index)
                    4'd1: begin
                        rtc.time_wp <= wr.data[1];
                        rtc.backup_wp <= wr.data[0];
                    end
                    4'd2: rtc.stopped <= wr.data[2];
                    default: ;
                endcase
            end
            if ((block_address[1:0] == 2'd2) && !rtc.time_wp) begin
                case (wr.index)
                    4'd1: rtc.second <= wr.data[6:0];
                    4'd2: rtc.minute <= wr.data[6:0];
                    4'd3: rtc.hour <= wr.data[5:0];
                    4'd4: rtc.day <= wr.data[5:0];
                    4'd5: rtc.weekday <= wr.data[2:0];
                    4'd6: rtc.month <= wr.data[4:0];
                    4'd7: rtc.year <= wr.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* design/joybus_reply.sv */
`timescale 1ns/1ps

module joybus_reply (
    input  logic                    clk,
    input  logic                    reset,
    input  joybus_pkg::joybus_cmd_e cmd,
    input  logic [7:0]              block_address,
    input  logic                    reply_start,
    input  logic                    eeprom_16k_mode,
    input  logic [7:0]              eeprom_rdata,
    input  joybus_pkg::rtc_regs_t   rtc,
    output joybus_pkg::tx_req_t     tx,
    input  logic                    tx_busy,
    output logic                    byte_taken
);

    import joybus_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e  state;
    logic [3:0] byte_count;
    logic [3:0] reply_length;
    logic [7:0] reply_byte;
    logic       req_valid;
    logic       req_stop;
    logic       stop_taken;

    assign byte_taken = req_valid && !tx_busy;
    assign stop_taken = req_stop && !tx_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TX_IDLE;
            req_valid <= 1'b0;
            req_stop <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (reply_start) begin
                        req_valid <= 1'b1;
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (byte_taken && (byte_count == reply_length)) begin
                        req_valid <= 1'b0;
                        req_stop <= 1'b1;
                        state <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (stop_taken) begin
                        req_stop <= 1'b0;
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE) begin
            byte_count <= '0;
        end else if (byte_taken) begin
            byte_count <= byte_count + 4'd1;
        end
    end

    // Length is the index of the last reply byte
    always_comb begin
        reply_length = 4'd0;
        reply_byte = 8'h00;
        case (cmd)
            EEPROM_STATUS: begin
                reply_length = 4'd2;
                if (byte_count == 4'd1) begin
                    reply_byte = {1'b1, eeprom_16k_mode, 6'd0};
                end
            end
            EEPROM_READ: begin
                reply_length = 4'd7;
                reply_byte = eeprom_rdata;
            end
            RTC_STATUS: begin
                reply_length = 4'd2;
                case (byte_count)
                    4'd1: reply_byte = 8'h10;
                    4'd2: reply_byte = {rtc.stopped, 7'd0};
                    default: ;
                endcase
            end
            RTC_READ: begin
                reply_length = 4'd8;
                if (block_address[1:0] == 2'd0) begin
                    case (byte_count)
                        4'd0: reply_byte = {6'd0, rtc.time_wp, rtc.backup_wp};
                        4'd1: reply_byte = {5'd0, rtc.stopped, 2'd0};
                        4'd8: reply_byte = {rtc.stopped, 7'd0};
                        default: ;
                    endcase
                end else if (block_address[1:0] == 2'd2) begin
                    case (byte_count)
                        4'd0: reply_byte = {1'b0, rtc.second};
                        4'd1: reply_byte = {1'b0, rtc.minute};
                        // 24 hour mode flag
                        4'd2: reply_byte = {2'b10, rtc.hour};
                        4'd3: reply_byte = {2'd0, rtc.day};
                        4'd4: reply_byte = {5'd0, rtc.weekday};
                        4'd5: reply_byte = {3'd0, rtc.month};
                        4'd6: reply_byte = rtc.year;
                        4'd7: reply_byte = 8'h01;
                        4'd8: reply_byte = {rtc.stopped, 7'd0};
                        default: ;
                    endcase
                end
            end
            RTC_WRITE: reply_byte = {rtc.stopped, 7'd0};
            default: ;
        endcase
    end

    always_comb begin
        tx.byte_valid = req_valid;
        tx.data = reply_byte;
        tx.stop = req_stop;
    end

endmodule

/* design/joybus_si.sv */
`timescale 1ns/1ps

module joybus_si (
    input  logic clk,
    input  logic reset,
    input  logic si_clk,
    input  logic dq_in,
    output logic dq_oe,
    input  logic eeprom_enabled,
    input  logic eeprom_16k_mode
);

    import joybus_pkg::*;

    si_rx_t      rx;
    tx_req_t     tx;
    rx_write_t   wr;
    rtc_regs_t   rtc;
    joybus_cmd_e cmd;
    logic [7:0]  block_address;
    logic [7:0]  eeprom_rdata;
    logic        reply_start;
    logic        tx_busy;
    logic        byte_taken;

    si_line_phy u_phy (
        .clk     (clk),
        .reset   (reset),
        .si_clk  (si_clk),
        .dq_in   (dq_in),
        .dq_oe   (dq_oe),
        .rx      (rx),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    joybus_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .eeprom_enabled (eeprom_enabled),
        .rx             (rx),
        .cmd            (cmd),
        .block_address  (block_address),
        .wr             (wr),
        .reply_start    (reply_start)
    );

    joybus_exec u_exec (
        .clk           (clk),
        .reset         (reset),
        .cmd           (cmd),
        .block_address (block_address),
        .wr            (wr),
        .byte_taken    (byte_taken),
        .eeprom_rdata  (eeprom_rdata),
        .rtc           (rtc)
    );

    joybus_reply u_reply (
        .clk             (clk),
        .reset           (reset),
        .cmd             (cmd),
        .block_address   (block_address),
        .reply_start     (reply_start),
        .eeprom_16k_mode (eeprom_16k_mode),
        .eeprom_rdata    (eeprom_rdata),
        .rtc             (rtc),
        .tx              (tx),
        .tx_busy         (tx_busy),
        .byte_taken      (byte_taken)
    );

endmodule

/* tb/joybus_host.sv */
`timescale 1ns/1ps

module joybus_host (
    input  logic clk,
    input  logic line,
    output logic si_clk,
    output logic drive
);

    // Low periods out of eight for each bit value sent
    localparam int ONE_LOW = 2;
    localparam int ZERO_LOW = 6;
    // Reply is over after this many high periods
    localparam int IDLE_END = 15;
    localparam int MAX_PERIODS = 2000;

    logic [7:0] rx_bytes [16];
    logic       sample;

    initial begin
        si_clk = 1'b1;
        drive = 1'b1;
        sample = 1'b1;
    end

    // One si_clk period of eight clk cycles, line sampled at its end
    task automatic si_period(input logic level);
        si_clk = 1'b0;
        drive = level;
        repeat (4) @(posedge clk);
        #2;
        si_clk = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        sample = line;
        #1;
    endtask

    task automatic send_bit(input logic value);
        int low;
        int s;
        low = value ? ONE_LOW : ZERO_LOW;
        for (s = 0; s < 8; s++) begin
            si_period(s >= low);
        end
    endtask

    // Bytes are taken MSB first from the top of data, then a stop bit
    task automatic send_command(input logic [79:0] data, input int count);
        int k;
        @(posedge clk);
        #2;
        for (k = 0; k < 8 * count; k++) begin
            send_bit(data[79 - k]);
        end
        send_bit(1'b1);
    endtask

    task automatic collect_reply(output int count, output int tail_bits,
                                 output logic tail_bit, output logic timed_out);
        int         highs;
        int         lows;
        int         bits;
        int         periods;
        logic [7:0] shift;
        logic       bit_value;
        count = 0;
        highs = 0;
        lows = 0;
        bits = 0;
        periods = 0;
        shift = 8'h00;
        timed_out = 1'b0;
        while (highs < IDLE_END && !timed_out) begin
            si_period(1'b1);
            periods++;
            if (!sample) begin
                lows++;
                highs = 0;
            end else begin
                highs++;
                if (lows > 0) begin
                    // Long low time means a 0
                    bit_value = (lows < 4);
                    shift = {shift[6:0], bit_value};
                    lows = 0;
                    bits++;
                    if (bits == 8) begin
                        if (count < 16) begin
                            rx_bytes[count] = shift;
                        end
                        count++;
                        bits = 0;
                    end
                end
            end
            if (periods >= MAX_PERIODS) begin
                timed_out = 1'b1;
            end
        end
        // Bits after the last whole byte
        tail_bits = bits;
        tail_bit = shift[0];
    endtask

endmodule

/* tb/tb_joybus_si.sv */
`timescale 1ns/1ps

module tb_joybus_si;

    localparam int ROWS = 19;
    localparam int REPLY_MAX = 9;

    logic clk;
    logic reset;
    logic si_clk;
    logic host_drive;
    logic line;
    logic dq_oe;
    logic eeprom_enabled;
    logic eeprom_16k_mode;

    string       row_name [ROWS];
    logic        row_enabled [ROWS];
    logic        row_16k [ROWS];
    logic [79:0] row_cmd [ROWS];
    int          row_cmd_len [ROWS];
    logic [71:0] row_reply [ROWS];
    int          row_reply_len [ROWS];

    int     rows_filled;
    int     tests_passed;
    int     tests_failed;
    integer seed;

    // Open-drain line shared by host and DUT
    assign line = host_drive & ~dq_oe;

    always #20 clk = ~clk;

    joybus_si DUT (
        .clk             (clk),
        .reset           (reset),
        .si_clk          (si_clk),
        .dq_in           (line),
        .dq_oe           (dq_oe),
        .eeprom_enabled  (eeprom_enabled),
        .eeprom_16k_mode (eeprom_16k_mode)
    );

    joybus_host host (
        .clk    (clk),
        .line   (line),
        .si_clk (si_clk),
        .drive  (host_drive)
    );

    task automatic add_row(input string name, input logic enabled, input logic mode_16k,
                           input logic [79:0] cmd, input int cmd_len,
                           input logic [71:0] reply, input int reply_len);
        row_name[rows_filled] = name;
        row_enabled[rows_filled] = enabled;
        row_16k[rows_filled] = mode_16k;
        row_cmd[rows_filled] = cmd;
        row_cmd_len[rows_filled] = cmd_len;
        row_reply[rows_filled] = reply;
        row_reply_len[rows_filled] = reply_len;
        rows_filled++;
    endtask

    task automatic build_table();
        integer      r0;
        integer      r1;
        integer      r2;
        integer      r3;
        logic [63:0] data_a;
        logic [63:0] data_b;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        data_a = {r0, r1};
        data_b = {r2, r3};
        // Status byte 1 reports 16k mode in bit 6
        add_row("EEPROM status 4k", 1'b1, 1'b0, {8'h00, 72'd0}, 1,
                {8'h00, 8'h80, 8'h00, 48'd0}, 3);
        add_row("EEPROM status 16k", 1'b1, 1'b1, {8'h00, 72'd0}, 1,
                {8'h00, 8'hc0, 8'h00, 48'd0}, 3);
        add_row("RTC status reset", 1'b1, 1'b0, {8'h06, 72'd0}, 1,
                {8'h00, 8'h10, 8'h00, 48'd0}, 3);
        // Both write-protect bits set after reset
        add_row("RTC read block 0 reset", 1'b1, 1'b0, {8'h07, 8'h00, 64'd0}, 2,
                72'h03_00_00_00_00_00_00_00_00, 9);
        add_row("EEPROM write block 5", 1'b1, 1'b0, {8'h05, 8'h05, data_a}, 10,
                {8'h00, 64'd0}, 1);
        add_row("EEPROM write block 6", 1'b1, 1'b0, {8'h05, 8'h06, data_b}, 10,
                {8'h00, 64'd0}, 1);
        add_row("EEPROM read block 5", 1'b1, 1'b0, {8'h04, 8'h05, 64'd0}, 2,
                {data_a, 8'h00}, 8);
        add_row("EEPROM read block 6", 1'b1, 1'b0, {8'h04, 8'h06, 64'd0}, 2,
                {data_b, 8'h00}, 8);
        // Disabled EEPROM stays silent
        add_row("EEPROM status disabled", 1'b0, 1'b0, {8'h00, 72'd0}, 1, 72'd0, 0);
        add_row("EEPROM write disabled", 1'b0, 1'b0, {8'h05, 8'h05, data_b}, 10, 72'd0, 0);
        add_row("EEPROM read disabled", 1'b0, 1'b0, {8'h04, 8'h05, 64'd0}, 2, 72'd0, 0);
        add_row("EEPROM read block 5 again", 1'b1, 1'b0, {8'h04, 8'h05, 64'd0}, 2,
                {data_a, 8'h00}, 8);
        add_row("RTC write block 2 protected", 1'b1, 1'b0,
                {8'h08, 8'h02, 64'h45_30_23_15_03_11_99_00}, 10, {8'h00, 64'd0}, 1);
        add_row("RTC read block 2 unchanged", 1'b1, 1'b0, {8'h07, 8'h02, 64'd0}, 2,
                72'h00_00_80_00_00_00_00_01_00, 9);
        // Clear both protect bits and set stopped
        add_row("RTC write block 0", 1'b1, 1'b0,
                {8'h08, 8'h00, 64'h00_04_00_00_00_00_00_00}, 10, {8'h80, 64'd0}, 1);
        add_row("RTC write block 2", 1'b1, 1'b0,
                {8'h08, 8'h02, 64'h45_30_23_15_03_11_99_00}, 10, {8'h80, 64'd0}, 1);
        // Hour carries the 24 hour flag in bit 7
        add_row("RTC read block 2 written", 1'b1, 1'b0, {8'h07, 8'h02, 64'd0}, 2,
                72'h45_30_a3_15_03_11_99_01_80, 9);
        add_row("RTC status stopped", 1'b1, 1'b0, {8'h06, 72'd0}, 1,
                {8'h00, 8'h10, 8'h80, 48'd0}, 3);
        add_row("RTC read block 0 cleared", 1'b1, 1'b0, {8'h07, 8'h00, 64'd0}, 2,
                72'h00_04_00_00_00_00_00_00_80, 9);
    endtask

    task automatic run_row(input int r);
        int         got;
        int         errors;
        int         i;
        int         tail_bits;
        int         stop_bits;
        logic       tail_bit;
        logic       timed_out;
        logic [7:0] expected;
        errors = 0;
        @(posedge clk);
        #2;
        eeprom_enabled = row_enabled[r];
        eeprom_16k_mode = row_16k[r];
        host.send_command(row_cmd[r], row_cmd_len[r]);
        host.collect_reply(got, tail_bits, tail_bit, timed_out);
        if (timed_out) begin
            $display("ERROR: %s reply never went idle within the host limit", row_name[r]);
            errors++;
        end
        if (got != row_reply_len[r]) begin
            $display("MISMATCH t=%0t %s reply_length expected %0d got %0d",
                     $time, row_name[r], row_reply_len[r], got);
            errors++;
        end
        for (i = 0; i < REPLY_MAX; i++) begin
            if (i < got && i < row_reply_len[r]) begin
                expected = row_reply[r][71 - 8 * i -: 8];
                if (host.rx_bytes[i] !== expected) begin
                    $display("MISMATCH t=%0t %s reply_byte[%0d] expected %02h got %02h",
                             $time, row_name[r], i, expected, host.rx_bytes[i]);
                    errors++;
                end
            end
        end
        // A reply ends in one stop bit, no reply leaves the line high
        stop_bits = (row_reply_len[r] > 0) ? 1 : 0;
        if (tail_bits != stop_bits) begin
            $display("MISMATCH t=%0t %s stop_bits expected %0d got %0d",
                     $time, row_name[r], stop_bits, tail_bits);
            errors++;
        end else if (stop_bits == 1 && tail_bit !== 1'b1) begin
            $display("MISMATCH t=%0t %s stop_bit expected 1 got %0b",
                     $time, row_name[r], tail_bit);
            errors++;
        end
        if (errors == 0) begin
            tests_passed++;
            $display("row %0d %s: ok", r, row_name[r]);
        end else begin
            tests_failed++;
            $display("row %0d %s: bad, %0d errors", r, row_name[r], errors);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        eeprom_enabled = 1'b0;
        eeprom_16k_mode = 1'b0;
        seed = 83689;
        rows_filled = 0;
        tests_passed = 0;
        tests_failed = 0;
        build_table();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int r = 0; r < rows_filled; r++) begin
            run_row(r);
        end
        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/joybus_pkg.sv
design/si_line_phy.sv
design/joybus_decode.sv
design/joybus_exec.sv
design/joybus_reply.sv
design/joybus_si.sv
tb/joybus_host.sv
tb/tb_joybus_si.sv

/* Makefile */
# Sources from the file list plus the config header
SOURCES := $(shell grep -v '^+' all.f) design/joybus_cfg.svh

obj_dir/Vtb_joybus_si: $(SOURCES) all.f
	verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_joybus_si

run: obj_dir/Vtb_joybus_si
	@out="$$(./obj_dir/Vtb_joybus_si)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
